/* rvAlu.sv */
`timescale 1ns/100ps

module rvAlu (
   input  rvCorePkg::decodedInstr_t dec,
   input  rvCorePkg::word_t         rs1Data,
   input  rvCorePkg::word_t         rs2Data,
   output rvCorePkg::aluResult_t    alu
);
   import rvCorePkg::*;

   word_t       op2;
   word_t       sum;
   logic [32:0] diff;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic [7:0]  f3Hot;

   // Second operand
   //   rs2 for register ops and branches
   //   immS for stores, immI otherwise
   assign op2 = (dec.isAluReg | dec.isBranch) ? rs2Data :
                (dec.isStore ? dec.immS : dec.immI);

   // Shared adder, also the load/store/JALR address
   assign sum = rs1Data + op2;

   // One 33-bit subtract gives difference and all compares
   assign diff = {1'b1, ~op2} + {1'b0, rs1Data} + 33'd1;
   assign ltu  = diff[32];
   // Signs differ: the negative one is smaller
   assign lt   = (rs1Data[31] ^ op2[31]) ? rs1Data[31] : diff[32];
   assign eq   = (diff[31:0] == '0);

   // funct3 as one-hot
   assign f3Hot = 8'b0000_0001 << dec.funct3;

   always_comb begin
      alu.sum = sum;
      alu.lt  = lt;
      alu.ltu = ltu;
      alu.eq  = eq;

      // Result mux, shift codes 1 and 5 give zero
      alu.result = ({xlen{f3Hot[0]}} & (dec.isSub ? diff[31:0] : sum))
                 | ({xlen{f3Hot[2]}} & word_t'(lt))
                 | ({xlen{f3Hot[3]}} & word_t'(ltu))
                 | ({xlen{f3Hot[4]}} & (rs1Data ^ op2))
                 | ({xlen{f3Hot[6]}} & (rs1Data | op2))
                 | ({xlen{f3Hot[7]}} & (rs1Data & op2));

      // Branch condition
      // BEQ BNE BLT BGE BLTU BGEU
      alu.predicate = (f3Hot[0] &  eq)
                    | (f3Hot[1] & ~eq)
                    | (f3Hot[4] &  lt)
                    | (f3Hot[5] & ~lt)
                    | (f3Hot[6] &  ltu)
                    | (f3Hot[7] & ~ltu);
   end

endmodule

/* rvControl.sv */
`timescale 1ns/100ps

module rvControl #(
   parameter int unsigned resetAddr = 0,
   parameter int unsigned addrWidth = 24
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     memRbusy,
   input  logic                     memWbusy,
   output rvCorePkg::memReq_t       mem,
   input  rvCorePkg::word_t         memRdata,
   output rvCorePkg::word_t         instr,
   output logic                     capture,
   input  rvCorePkg::decodedInstr_t dec,
   input  rvCorePkg::aluResult_t    alu,
   input  rvCorePkg::word_t         rs2Data,
   output logic                     writeEnable,
   output rvCorePkg::regIdx_t       writeIdx,
   output rvCorePkg::word_t         writeData
);
   import rvCorePkg::*;

   // ********************************************************************
   // One-hot states
   // ********************************************************************
   localparam int sFetch     = 0;
   localparam int sWaitInstr = 1;
   localparam int sExecute   = 2;
   localparam int sLoad      = 3;
   localparam int sStore     = 4;
   localparam int sWaitMem   = 5;
   localparam int numStates  = 6;

   // addi x0, x0, 0
   localparam word_t nopInstr = 32'h0000_0013;

   logic [numStates-1:0] state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] addrReg;
   word_t                instrReg;

   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] jalrTarget;
   word_t                jumpImm;
   word_t                auipcValue;
   logic                 jumpTaken;

   // ********************************************************************
   // Next PC candidates
   // ********************************************************************
   assign pcPlus4    = pc + addrWidth'(4);
   assign jumpImm    = dec.isJal ? dec.immJ : dec.immB;
   assign pcPlusImm  = pc + jumpImm[addrWidth-1:0];
   // JALR target drops bit 0
   assign jalrTarget = {alu.sum[addrWidth-1:1], 1'b0};
   assign jumpTaken  = dec.isJal | (dec.isBranch & alu.predicate);

   // AUIPC done on the full word
   assign auipcValue = word_t'(pc) + dec.immU;

   // Operands captured as the instruction word arrives
   assign capture = state[sWaitInstr] & ~memRbusy;
   assign instr   = instrReg;

   // Memory request, word stores only
   always_comb begin
      mem.addr  = word_t'(addrReg);
      mem.wdata = rs2Data;
      mem.wmask = {4{state[sStore]}};
      mem.rstrb = state[sFetch] | state[sLoad];
   end

   // Write-back, in execute or at load completion
   assign writeIdx    = dec.rd;
   assign writeEnable = (state[sExecute] & (dec.isAluImm | dec.isAluReg | dec.isLui
                                          | dec.isAuipc | dec.isJal | dec.isJalr))
                      | (state[sWaitMem] & dec.isLoad & ~memRbusy);
   assign writeData   = dec.isLui                 ? dec.immU        :
                        dec.isAuipc               ? auipcValue      :
                        (dec.isJal | dec.isJalr)  ? word_t'(pcPlus4) :
                        dec.isLoad                ? memRdata        :
                                                    alu.result;

   // ********************************************************************
   // Sequencer
   // ********************************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         // Park in waitMem until write busy drops
         state    <= numStates'(1) << sWaitMem;
         pc       <= addrWidth'(resetAddr);
         instrReg <= nopInstr;
      end else begin
         case (1'b1)
            state[sFetch]: begin
               state <= numStates'(1) << sWaitInstr;
            end
            state[sWaitInstr]: begin
               if (!memRbusy) begin
                  instrReg <= memRdata;
                  state    <= numStates'(1) << sExecute;
               end
            end
            state[sExecute]: begin
               pc      <= dec.isJalr ? jalrTarget : (jumpTaken ? pcPlusImm : pcPlus4);
               // Data address for loads and stores, else next fetch
               addrReg <= (dec.isLoad | dec.isStore) ? alu.sum[addrWidth-1:0] :
                          dec.isJalr                 ? jalrTarget :
                          jumpTaken                  ? pcPlusImm  : pcPlus4;
               state   <= dec.isLoad  ? numStates'(1) << sLoad  :
                          dec.isStore ? numStates'(1) << sStore :
                                        numStates'(1) << sFetch;
            end
            state[sLoad], state[sStore]: begin
               state <= numStates'(1) << sWaitMem;
            end
            state[sWaitMem]: begin
               // Hold the request until both busy lines drop
               if (!memRbusy && !memWbusy) begin
                  addrReg <= pc;
                  state   <= numStates'(1) << sFetch;
               end
            end
            default: begin
               state <= numStates'(1) << sWaitMem;
            end
         endcase
      end
   end

endmodule

/* rvCore.f */
+incdir+.
rvCorePkg.sv
rvDecoder.sv
rvRegFile.sv
rvAlu.sv
rvControl.sv
rvCore.sv
tbRvCore.sv

/* rvCore.sv */
`timescale 1ns/100ps

module rvCore #(
   parameter int unsigned resetAddr = 0,
   parameter int unsigned addrWidth = 24
) (
   input  logic               clk,
   input  logic               reset,
   output rvCorePkg::memReq_t mem,
   input  rvCorePkg::word_t   memRdata,
   input  logic               memRbusy,
   input  logic               memWbusy
);
   import rvCorePkg::*;

   // Latched instruction and its decode
   word_t         instr;
   decodedInstr_t dec;

   // Operands and ALU outputs
   logic          capture;
   word_t         rs1Data;
   word_t         rs2Data;
   aluResult_t    alu;

   // Register write port
   logic          writeEnable;
   regIdx_t       writeIdx;
   word_t         writeData;

   rvDecoder uDecoder (
      .instr (instr),
      .dec   (dec)
   );

   // Source indices come straight off the read data bus
   rvRegFile uRegFile (
      .clk         (clk),
      .instrWord   (memRdata),
      .capture     (capture),
      .rs1Data     (rs1Data),
      .rs2Data     (rs2Data),
      .writeEnable (writeEnable),
      .writeIdx    (writeIdx),
      .writeData   (writeData)
   );

   rvAlu uAlu (
      .dec     (dec),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .alu     (alu)
   );

   rvControl #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) uControl (
      .clk         (clk),
      .reset       (reset),
      .memRbusy    (memRbusy),
      .memWbusy    (memWbusy),
      .mem         (mem),
      .memRdata    (memRdata),
      .instr       (instr),
      .capture     (capture),
      .dec         (dec),
      .alu         (alu),
      .rs2Data     (rs2Data),
      .writeEnable (writeEnable),
      .writeIdx    (writeIdx),
      .writeData   (writeData)
   );

endmodule

/* rvCorePkg.sv */
package rvCorePkg;

   // ********************************************************************
   // Widths
   // ********************************************************************

   // Data word and register index widths
   localparam int xlen         = 32;
   localparam int regAddrWidth = 5;

   typedef logic [xlen-1:0]         word_t;
   typedef logic [regAddrWidth-1:0] regIdx_t;

   // ********************************************************************
   // Opcode classes, instruction bits 6:2
   // ********************************************************************

   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcode_t;

   // Decoded instruction, one class flag at most is set
   typedef struct packed {
      logic    isLoad;
      logic    isStore;
      logic    isAluImm;
      logic    isAluReg;
      logic    isLui;
      logic    isAuipc;
      logic    isBranch;
      logic    isJal;
      logic    isJalr;
      regIdx_t rd;
      logic [2:0] funct3;
      // SUB only for register form, bit 30 AND bit 5
      logic    isSub;
      word_t   immI;
      word_t   immS;
      word_t   immB;
      word_t   immJ;
      word_t   immU;
   } decodedInstr_t;

   // Memory bus request
   typedef struct packed {
      word_t      addr;
      word_t      wdata;
      logic [3:0] wmask;
      logic       rstrb;
   } memReq_t;

   // ALU outputs, sum also serves address generation
   typedef struct packed {
      word_t sum;
      word_t result;
      logic  lt;
      logic  ltu;
      logic  eq;
      logic  predicate;
   } aluResult_t;

endpackage

/* rvDecoder.sv */
`timescale 1ns/100ps

module rvDecoder (
   input  rvCorePkg::word_t         instr,
   output rvCorePkg::decodedInstr_t dec
);
   import rvCorePkg::*;

   // Opcode field, the two LSBs are always 11 in RV32I
   opcode_t op;

   assign op = opcode_t'(instr[6:2]);

   always_comb begin
      // ********************************************************************
      // Opcode classes
      // ********************************************************************
      // Unknown opcodes leave every flag low and act as no-ops
      dec.isLoad   = (op == opLoad);
      dec.isStore  = (op == opStore);
      dec.isAluImm = (op == opAluImm);
      dec.isAluReg = (op == opAluReg);
      dec.isLui    = (op == opLui);
      dec.isAuipc  = (op == opAuipc);
      dec.isBranch = (op == opBranch);
      dec.isJal    = (op == opJal);
      dec.isJalr   = (op == opJalr);

      // Destination and function fields
      dec.rd     = instr[11:7];
      dec.funct3 = instr[14:12];

      // ADDI has bit 30 as part of its immediate, so bit 5 separates it
      dec.isSub = instr[30] & instr[5];

      // ********************************************************************
      // Immediate formats
      // ********************************************************************
      // I type, loads, JALR and ALU immediates
      dec.immI = {{21{instr[31]}}, instr[30:20]};

      // S type, offset split around rs2
      dec.immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};

      // B type, halfword offset
      dec.immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

      // J type, halfword offset with scrambled fields
      dec.immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

      // U type, upper 20 bits
      dec.immU = {instr[31:12], 12'b0};
   end

endmodule

/* rvRegFile.sv */
`timescale 1ns/100ps

module rvRegFile (
   input  logic               clk,
   input  rvCorePkg::word_t   instrWord,
   input  logic               capture,
   output rvCorePkg::word_t   rs1Data,
   output rvCorePkg::word_t   rs2Data,
   input  logic               writeEnable,
   input  rvCorePkg::regIdx_t writeIdx,
   input  rvCorePkg::word_t   writeData
);
   import rvCorePkg::*;

   // 32 general registers, entry 0 is never written
   word_t   regs [0:2**regAddrWidth-1];
   regIdx_t rs1Idx;
   regIdx_t rs2Idx;

   // Source indices taken straight from the arriving word
   assign rs1Idx = instrWord[19:15];
   assign rs2Idx = instrWord[24:20];

   // Operands are read once, when the instruction lands
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1Data <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2Data <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

   // Write port, x0 writes dropped
   always_ff @(posedge clk) begin
      if (writeEnable && (writeIdx != '0)) begin
         regs[writeIdx] <= writeData;
      end
   end

endmodule

/* tbRvModel.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ********************************************************************
// Random source
// ********************************************************************

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic word_t randBits(input int n);
   word_t v;
   int    i;
   v = '0;
   for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
   end
   return v;
endfunction

// ********************************************************************
// Instruction-set reference
// ********************************************************************

// Integer ops by funct3, shift codes never generated
function automatic word_t aluRef(input logic [2:0] f3, input logic sub,
                                 input word_t a, input word_t b);
   case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd2:    return word_t'($signed(a) < $signed(b));
      3'd3:    return word_t'(a < b);
      3'd4:    return a ^ b;
      3'd6:    return a | b;
      3'd7:    return a & b;
      default: return '0;
   endcase
endfunction

// Branch conditions by funct3
function automatic bit branchRef(input logic [2:0] f3, input word_t a, input word_t b);
   case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
   endcase
endfunction

// Runs the image until the self jump, queues every store in order
function automatic void refRun();
   word_t r [0:31];
   word_t m [0:memWords-1];
   word_t pc;
   word_t nextPc;
   word_t ins;
   word_t a;
   word_t b;
   word_t v;
   word_t immI;
   word_t immS;
   word_t ea;
   bit    wr;
   int    step;
   m = memImg;
   foreach (r[k]) r[k] = '0;
   pc = word_t'(resetAddr);
   for (step = 0; step < 4000; step++) begin
      ins    = m[pc[11:2]];
      a      = r[ins[19:15]];
      b      = r[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      nextPc = pc + 4;
      wr     = 1'b1;
      v      = '0;
      case (ins[6:0])
         // LUI, AUIPC
         7'b0110111: v = {ins[31:12], 12'b0};
         7'b0010111: v = pc + {ins[31:12], 12'b0};
         7'b1101111: begin
            v      = pc + 4;
            nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'b1100111: begin
            v      = pc + 4;
            nextPc = (a + immI) & ~32'd1;
         end
         7'b1100011: begin
            wr = 1'b0;
            if (branchRef(ins[14:12], a, b)) begin
               nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         7'b0000011: begin
            ea = a + immI;
            v  = m[ea[11:2]];
         end
         7'b0100011: begin
            wr         = 1'b0;
            ea         = a + immS;
            m[ea[11:2]] = b;
            expAddr.push_back(ea);
            expData.push_back(b);
            expName.push_back(storeName.exists(pc) ? storeName[pc] : "stray store");
         end
         7'b0010011: v = aluRef(ins[14:12], 1'b0, a, immI);
         7'b0110011: v = aluRef(ins[14:12], ins[30], a, b);
         default:    wr = 1'b0;
      endcase
      // x0 stays zero
      if (wr && ins[11:7] != 5'd0) r[ins[11:7]] = v;
      if (nextPc == pc) break;
      pc = nextPc;
   end
endfunction

// ********************************************************************
// Compare tasks
// ********************************************************************

task automatic checkAddr(input string name, input word_t expected, input word_t actual);
   if (actual !== expected) begin
      failRun($sformatf("FAILED %s: address expected %h, actual %h", name, expected, actual));
   end
endtask

task automatic checkData(input string name, input word_t expected, input word_t actual);
   if (actual !== expected) begin
      failRun($sformatf("FAILED %s: data expected %h, actual %h", name, expected, actual));
   end
endtask

`endif

/* tbRvCore.sv */
`timescale 1ns/100ps

module tbRvCore;
   import rvCorePkg::*;

   localparam int unsigned resetAddr = 0;
   localparam int unsigned addrWidth = 24;
   // 4 KB image with the program at 0 and the data regions above it
   localparam int memWords     = 1024;
   localparam int dataBase     = 'h400;
   localparam int copyBase     = 'h500;
   localparam int resultBase   = 'h600;
   localparam int fetchTimeout = 20;
   localparam int storeTimeout = 400;

   logic    clk;
   logic    reset;
   memReq_t mem;
   word_t   memRdata;
   logic    memRbusy;
   logic    memWbusy;

   word_t       memImg [0:memWords-1];
   logic [15:0] lfsrState = 16'd49455;
   int          busyCount;
   // Busy cycles drawn for the current request
   int          busyLen;
   int          pcCount;
   int          storeSlot;
   // Test name per store instruction keyed by its byte address
   string       storeName [int];
   word_t       expAddr [$];
   word_t       expData [$];
   string       expName [$];
   word_t       actAddr [$];
   word_t       actData [$];

   rvCore #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) rvCore_inst (
      .clk      (clk),
      .reset    (reset),
      .mem      (mem),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   `include "tbRvModel.svh"

   // ********************************************************************
   // Program image
   // ********************************************************************
   function automatic word_t encI(input logic [11:0] imm, input regIdx_t rs1,
                                  input logic [2:0] f3, input regIdx_t rd, input opcode_t op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   // SW only
   function automatic word_t encS(input logic [11:0] imm, input regIdx_t rs2, input regIdx_t rs1);
      return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic word_t encB(input logic [12:0] imm, input regIdx_t rs1,
                                  input regIdx_t rs2, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic word_t encU(input logic [19:0] imm, input regIdx_t rd, input opcode_t op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic word_t encJ(input logic [20:0] imm, input regIdx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   function automatic void emit(input word_t w);
      memImg[pcCount] = w;
      pcCount++;
   endfunction

   // Result store into the next free slot
   function automatic void emitStore(input string name, input regIdx_t rs2);
      storeName[pcCount * 4] = name;
      emit(encS(resultBase + 4 * storeSlot, rs2, 0));
      storeSlot++;
   endfunction

   task automatic buildProgram();
      logic [2:0] regOps [0:6] = '{0, 0, 2, 3, 4, 6, 7};
      logic [2:0] immOps [0:5] = '{0, 2, 3, 4, 6, 7};
      logic [2:0] brOps  [0:5] = '{0, 1, 4, 5, 6, 7};
      regIdx_t    srcA   [0:2] = '{1, 2, 1};
      regIdx_t    srcB   [0:2] = '{2, 1, 1};
      int         i;
      int         k;
      int         marker;
      // Odd multiplier keeps every background word distinct
      foreach (memImg[j]) memImg[j] = 32'h9E37_79B9 * (j + 1);
      memImg[dataBase / 4]     = randBits(32);
      memImg[dataBase / 4 + 1] = randBits(32);
      for (k = 0; k < 4; k++) memImg[copyBase / 4 + k] = randBits(32);
      pcCount   = resetAddr / 4;
      storeSlot = 0;
      // Operands into x1 and x2
      emit(encI(dataBase, 0, 3'd2, 1, opLoad));
      emit(encI(dataBase + 4, 0, 3'd2, 2, opLoad));
      // Register forms with entry 1 as SUB
      for (i = 0; i < 7; i++) begin
         emit(encI({(i == 1) ? 7'h20 : 7'h00, 5'd2}, 1, regOps[i], 3, opAluReg));
         emitStore($sformatf("reg alu funct3 %0d sub %0d", regOps[i], i == 1), 3);
      end
      for (i = 0; i < 6; i++) begin
         emit(encI(randBits(12), 1, immOps[i], 3, opAluImm));
         emitStore($sformatf("imm alu funct3 %0d", immOps[i]), 3);
      end
      emit(encI(randBits(12), 1, 3'd0, 0, opAluImm));
      emitStore("x0 write", 0);
      emit(encU(randBits(20), 4, opLui));
      emitStore("lui", 4);
      emit(encU(randBits(20), 5, opAuipc));
      emitStore("auipc", 5);
      // Each branch compares x1 with x2, x2 with x1 and x1 with itself
      // Odd marker means the branch was taken
      for (i = 0; i < 6; i++) begin
         for (k = 0; k < 3; k++) begin
            marker = 16 * i + 2 * k;
            emit(encB(12, srcA[k], srcB[k], brOps[i]));
            emit(encI(marker, 0, 3'd0, 6, opAluImm));
            emit(encJ(8, 0));
            emit(encI(marker + 1, 0, 3'd0, 6, opAluImm));
            emitStore($sformatf("branch funct3 %0d case %0d", brOps[i], k), 6);
         end
      end
      // Jumps skip a stray store
      emit(encJ(8, 7));
      emit(encS(12'h7FC, 0, 0));
      emitStore("jal link", 7);
      emit(encU(20'h0, 8, opAuipc));
      // Odd offset so target bit 0 is dropped
      emit(encI(13, 8, 3'd0, 9, opJalr));
      emit(encS(12'h7FC, 0, 0));
      emitStore("jalr link", 9);
      for (k = 0; k < 4; k++) begin
         emit(encI(copyBase + 4 * k, 0, 3'd2, 10, opLoad));
         emitStore($sformatf("copy word %0d", k), 10);
      end
      // Park on a self jump
      emit(encJ(0, 0));
   endtask

   // ********************************************************************
   // Memory model sampling requests on the falling edge
   // ********************************************************************
   always @(negedge clk) begin
      if (busyCount > 0) begin
         busyCount <= busyCount - 1;
      end else begin
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
      end
      // Zero draw means no busy cycle at all
      if (mem.rstrb === 1'b1) begin
         busyLen    = int'(randBits(2));
         memRdata  <= memImg[mem.addr[11:2]];
         memRbusy  <= (busyLen != 0);
         busyCount <= (busyLen > 0) ? busyLen - 1 : 0;
      end
      if (mem.wmask != 4'b0000) begin
         if (mem.wmask !== 4'b1111) failRun("store issued without a full word mask");
         memImg[mem.addr[11:2]] = mem.wdata;
         actAddr.push_back(mem.addr);
         actData.push_back(mem.wdata);
         busyLen    = int'(randBits(2));
         memWbusy  <= (busyLen != 0);
         busyCount <= (busyLen > 0) ? busyLen - 1 : 0;
      end
   end

   // ********************************************************************
   // Reset, first fetch and store compare
   // ********************************************************************
   initial begin
      int    cycles;
      string name;
      reset      = 1'b0;
      memRdata  <= '0;
      memRbusy  <= 1'b0;
      memWbusy  <= 1'b0;
      busyCount <= 0;
      buildProgram();
      refRun();
      if (expAddr.size() != storeSlot) begin
         failRun("reference model store count differs from the program");
      end
      // No request may leave the core while reset is low
      repeat (2) begin
         @(negedge clk);
         if (mem.rstrb !== 1'b0 || mem.wmask !== 4'b0000) begin
            failRun("memory request active while reset is low");
         end
      end
      reset  = 1'b1;
      cycles = 0;
      while (mem.rstrb !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > fetchTimeout) failRun("timeout waiting for the first instruction fetch");
      end
      checkAddr("reset fetch", word_t'(resetAddr), mem.addr);
      // Stores in program order against the reference queue
      while (expAddr.size() != 0) begin
         cycles = 0;
         while (actAddr.size() == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > storeTimeout) begin
               failRun($sformatf("timeout waiting for store %s", expName[0]));
            end
         end
         name = expName.pop_front();
         checkAddr(name, expAddr.pop_front(), actAddr.pop_front());
         checkData(name, expData.pop_front(), actData.pop_front());
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule
